//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_core_dec
OBJ_DIR   ?= obj_dir
FLIST     ?= build.f
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard hw/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(OBJ_DIR)/V%: $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $* --Mdir $(OBJ_DIR) -o V$*

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+hw
hw/core_isa_pkg.sv
hw/core_ctrl_pkg.sv
hw/core_imm_gen.sv
hw/core_reg_file.sv
hw/core_dec_s.sv
hw/core_dec_top.sv
testbench/core_dec_chk.sv
testbench/tb_core_dec.sv

//--- hw/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

	// ---------------------------------------------------------------------------
	// Execute controls
	// ---------------------------------------------------------------------------
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLT  = 4'd2,
		ALU_SLTU = 4'd3,
		ALU_AND  = 4'd4,
		ALU_OR   = 4'd5,
		ALU_XOR  = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8,
		ALU_SRA  = 4'd9
	} alu_op_e;

	typedef enum logic [2:0] {
		CND_NONE = 3'd0,  // Not a branch
		CND_EQ   = 3'd1,
		CND_NE   = 3'd2,
		CND_LT   = 3'd3,
		CND_LTU  = 3'd4
	} alu_cnd_e;

	// Operand selection in execute, one code per instruction group
	typedef enum logic [5:0] {
		MUX_NONE  = 6'd0,
		MUX_R     = 6'd1,
		MUX_I_R   = 6'd2,
		MUX_LUI   = 6'd3,
		MUX_AUIPC = 6'd4,
		MUX_SB    = 6'd5,
		MUX_UJ    = 6'd6,
		MUX_JALR  = 6'd7,
		MUX_LD    = 6'd8,
		MUX_ST    = 6'd9
	} mux_sel_e;

	// ---------------------------------------------------------------------------
	// Writeback, memory and hazard
	// ---------------------------------------------------------------------------
	typedef enum logic [2:0] {
		WB_PASS = 3'd0,
		WB_B    = 3'd1,
		WB_UB   = 3'd2,
		WB_H    = 3'd3,
		WB_UH   = 3'd4,
		WB_IMM  = 3'd5,  // LUI result straight from the immediate
		WB_PC   = 3'd6   // Link address for jumps
	} wb_ext_e;

	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_size_e;

	typedef enum logic [1:0] {
		HAZ_OTHER  = 2'd0,
		HAZ_LOAD   = 2'd1,
		HAZ_BRANCH = 2'd2,
		HAZ_JUMP   = 2'd3
	} hazard_cmd_e;

endpackage

`default_nettype wire

//--- hw/core_dec_s.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

module core_dec_s
	import core_isa_pkg::*;
	import core_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        dec_enb,
	input  logic        dec_kill,
	input  logic        dec_nop_gen_in,
	input  logic        dec_il1_ack_in,
	input  inst_t       dec_inst_in,
	input  word_t       dec_pc_in,
	input  word_t       dec_pc_4_in,
	input  logic        wb_we,
	input  reg_idx_t    wb_rd,
	input  word_t       wb_data,
	output wb_ext_e     dec_wb_ext_out_reg,
	output mux_sel_e    dec_mux_bus_out_reg,
	output logic        dec_we_reg_file_out_reg,
	output alu_op_e     dec_alu_op_out_reg,
	output alu_cnd_e    dec_alu_cnd_out_reg,
	output hazard_cmd_e dec_hazard_cmd_out_reg,
	output logic        dec_l1d_req_val_out_reg,
	output logic        dec_l1d_req_wr_out_reg,
	output mem_size_e   dec_l1d_req_size_out_reg,
	output word_t       dec_src1_out_reg,
	output word_t       dec_src2_out_reg,
	output word_t       dec_imm_out_reg,
	output word_t       dec_pc_out_reg,
	output word_t       dec_pc_4_out_reg,
	output reg_idx_t    dec_rs1_out_reg,
	output reg_idx_t    dec_rs2_out_reg,
	output reg_idx_t    dec_rd_out_reg,
	output hazard_cmd_e dec2haz_cmd_out,
	output logic        dec_stall_out
);

	opcode_e     opcode;
	funct3_t     funct3;
	funct7_e     funct7;
	imm_kind_e   imm_kind;
	alu_op_e     alu_op;
	alu_cnd_e    alu_cnd;
	mux_sel_e    mux_sel;
	wb_ext_e     wb_ext;
	mem_size_e   l1d_size;
	hazard_cmd_e haz_cmd;
	logic        we_loc;
	logic        order;
	logic        l1d_val;
	logic        l1d_wr;
	logic        we_nop;
	logic        l1d_val_nop;
	reg_idx_t    rs1;
	reg_idx_t    rs2;
	reg_idx_t    rd;
	word_t       src1;
	word_t       src2;
	word_t       imm;

	assign opcode = opcode_e'(dec_inst_in[6:0]);
	assign funct3 = dec_inst_in[14:12];
	assign funct7 = funct7_e'(dec_inst_in[31:25]);

	// Shared by R-type and OP-IMM
	function automatic alu_op_e f3_alu_op(funct3_t f3);
		case (f3)
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SR:   return ALU_SRL;
			F3_OR:   return ALU_OR;
			F3_AND:  return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	// ---------------------------------------------------------------------------
	// Control unit
	// ---------------------------------------------------------------------------
	always_comb begin
		alu_op   = ALU_ADD;  // Defaults describe a bubble
		alu_cnd  = CND_NONE;
		mux_sel  = MUX_NONE;
		wb_ext   = WB_PASS;
		we_loc   = 1'b0;
		order    = 1'b0;
		imm_kind = IMM_NONE;
		l1d_val  = 1'b0;
		l1d_wr   = 1'b0;
		l1d_size = MEM_BYTE;
		haz_cmd  = HAZ_OTHER;
		case (opcode)
			OPC_R: begin
				mux_sel = MUX_R;
				we_loc  = 1'b1;
				case (funct7)
					F7_BASE: alu_op = f3_alu_op(funct3);
					F7_ALT: begin
						if (funct3 == F3_ADD) begin
							alu_op = ALU_SUB;
						end else if (funct3 == F3_SR) begin
							alu_op = ALU_SRA;
						end else begin
							mux_sel = MUX_NONE;
							we_loc  = 1'b0;
						end
					end
					default: begin
						mux_sel = MUX_NONE;  // M extension and others
						we_loc  = 1'b0;
					end
				endcase
			end
			OPC_I_R: begin
				mux_sel  = MUX_I_R;
				we_loc   = 1'b1;
				imm_kind = IMM_I;
				alu_op   = f3_alu_op(funct3);
				if (funct3 == F3_SR && funct7 == F7_ALT)
					alu_op = ALU_SRA;  // SRAI
			end
			OPC_LUI: begin
				mux_sel  = MUX_LUI;
				we_loc   = 1'b1;
				imm_kind = IMM_U;
				wb_ext   = WB_IMM;
			end
			OPC_AUIPC: begin
				mux_sel  = MUX_AUIPC;
				we_loc   = 1'b1;
				imm_kind = IMM_U;
			end
			OPC_SB: begin
				mux_sel  = MUX_SB;
				imm_kind = IMM_B;
				haz_cmd  = HAZ_BRANCH;
				case (funct3)
					F3_BEQ:  alu_cnd = CND_EQ;
					F3_BNE:  alu_cnd = CND_NE;
					F3_BLT:  alu_cnd = CND_LT;
					F3_BLTU: alu_cnd = CND_LTU;
					F3_BGE: begin
						alu_cnd = CND_LT;
						order   = 1'b1;  // Operands come back swapped
					end
					F3_BGEU: begin
						alu_cnd = CND_LTU;
						order   = 1'b1;
					end
					default: begin
						mux_sel = MUX_NONE;
						haz_cmd = HAZ_OTHER;
					end
				endcase
			end
			OPC_UJ, OPC_JALR: begin
				mux_sel  = (opcode == OPC_UJ) ? MUX_UJ : MUX_JALR;
				imm_kind = (opcode == OPC_UJ) ? IMM_J : IMM_I;
				we_loc   = 1'b1;
				wb_ext   = WB_PC;
				haz_cmd  = HAZ_JUMP;
			end
			OPC_LD: begin
				mux_sel  = MUX_LD;
				we_loc   = 1'b1;
				imm_kind = IMM_I;
				haz_cmd  = HAZ_LOAD;
				l1d_val  = 1'b1;
				case (funct3)
					F3_LB:  wb_ext = WB_B;
					F3_LBU: wb_ext = WB_UB;
					F3_LH: begin
						l1d_size = MEM_HALF;
						wb_ext   = WB_H;
					end
					F3_LHU: begin
						l1d_size = MEM_HALF;
						wb_ext   = WB_UH;
					end
					F3_LW:  l1d_size = MEM_WORD;
					default: begin
						mux_sel = MUX_NONE;
						we_loc  = 1'b0;
						haz_cmd = HAZ_OTHER;
						l1d_val = 1'b0;
					end
				endcase
			end
			OPC_ST: begin
				mux_sel  = MUX_ST;
				imm_kind = IMM_S;
				l1d_val  = 1'b1;
				l1d_wr   = 1'b1;
				case (funct3)
					F3_SB:  wb_ext = WB_B;
					F3_SH: begin
						l1d_size = MEM_HALF;
						wb_ext   = WB_H;
					end
					F3_SW:  l1d_size = MEM_WORD;
					default: begin
						mux_sel = MUX_NONE;
						l1d_val = 1'b0;
						l1d_wr  = 1'b0;
					end
				endcase
			end
			default: ;  // Unknown opcode stays a bubble
		endcase
	end

	// Bubble mask
	assign we_nop      = we_loc & ~dec_nop_gen_in;
	assign l1d_val_nop = l1d_val & ~dec_nop_gen_in;
	assign rs1         = dec_nop_gen_in ? '0 : dec_inst_in[19:15];
	assign rs2         = dec_nop_gen_in ? '0 : dec_inst_in[24:20];
	assign rd          = dec_nop_gen_in ? '0 : dec_inst_in[11:7];

	core_reg_file u_reg_file (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (wb_rd),
		.we       (wb_we),
		.data_in  (wb_data),
		.order    (order),
		.src1_out (src1),
		.src2_out (src2)
	);

	core_imm_gen u_imm_gen (
		.inst (dec_inst_in),
		.kind (imm_kind),
		.imm  (imm)
	);

	assign dec2haz_cmd_out = haz_cmd;       // Same cycle, to hazard unit
	assign dec_stall_out   = ~dec_il1_ack_in;

	// ---------------------------------------------------------------------------
	// Output registers toward execute, kill over enable
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_wb_ext_out_reg       <= WB_PASS;
			dec_mux_bus_out_reg      <= MUX_NONE;
			dec_we_reg_file_out_reg  <= 1'b0;
			dec_alu_op_out_reg       <= ALU_ADD;
			dec_alu_cnd_out_reg      <= CND_NONE;
			dec_hazard_cmd_out_reg   <= HAZ_OTHER;
			dec_l1d_req_val_out_reg  <= 1'b0;
			dec_l1d_req_wr_out_reg   <= 1'b0;
			dec_l1d_req_size_out_reg <= MEM_BYTE;
			dec_src1_out_reg         <= '0;
			dec_src2_out_reg         <= '0;
			dec_imm_out_reg          <= '0;
			dec_pc_out_reg           <= `CORE_RESET_PC;
			dec_pc_4_out_reg         <= `CORE_RESET_PC;
			dec_rs1_out_reg          <= '0;
			dec_rs2_out_reg          <= '0;
			dec_rd_out_reg           <= '0;
		end else if (dec_kill) begin
			dec_wb_ext_out_reg       <= WB_PASS;
			dec_mux_bus_out_reg      <= MUX_NONE;
			dec_we_reg_file_out_reg  <= 1'b0;
			dec_alu_op_out_reg       <= ALU_ADD;
			dec_alu_cnd_out_reg      <= CND_NONE;
			dec_hazard_cmd_out_reg   <= HAZ_OTHER;
			dec_l1d_req_val_out_reg  <= 1'b0;
			dec_l1d_req_wr_out_reg   <= 1'b0;
			dec_l1d_req_size_out_reg <= MEM_BYTE;
			dec_src1_out_reg         <= '0;
			dec_src2_out_reg         <= '0;
			dec_imm_out_reg          <= '0;
			dec_pc_out_reg           <= '0;
			dec_pc_4_out_reg         <= '0;
			dec_rs1_out_reg          <= '0;
			dec_rs2_out_reg          <= '0;
			dec_rd_out_reg           <= '0;
		end else if (dec_enb) begin
			dec_wb_ext_out_reg       <= wb_ext;
			dec_mux_bus_out_reg      <= mux_sel;
			dec_we_reg_file_out_reg  <= we_nop;
			dec_alu_op_out_reg       <= alu_op;
			dec_alu_cnd_out_reg      <= alu_cnd;
			dec_hazard_cmd_out_reg   <= haz_cmd;
			dec_l1d_req_val_out_reg  <= l1d_val_nop;
			dec_l1d_req_wr_out_reg   <= l1d_wr;
			dec_l1d_req_size_out_reg <= l1d_size;
			dec_src1_out_reg         <= src1;
			dec_src2_out_reg         <= src2;
			dec_imm_out_reg          <= imm;
			dec_pc_out_reg           <= dec_pc_in;
			dec_pc_4_out_reg         <= dec_pc_4_in;
			dec_rs1_out_reg          <= rs1;
			dec_rs2_out_reg          <= rs2;
			dec_rd_out_reg           <= rd;
		end
	end

endmodule

`default_nettype wire

//--- hw/core_dec_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_dec_top
	import core_isa_pkg::*;
	import core_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        dec_enb,
	input  logic        dec_kill,
	input  logic        dec_nop_gen_in,
	input  logic        dec_il1_ack_in,
	input  inst_t       dec_inst_in,
	input  word_t       dec_pc_in,
	input  word_t       dec_pc_4_in,
	input  logic        wb_we,        // Writeback port
	input  reg_idx_t    wb_rd,
	input  word_t       wb_data,
	output wb_ext_e     dec_wb_ext_out_reg,
	output mux_sel_e    dec_mux_bus_out_reg,
	output logic        dec_we_reg_file_out_reg,
	output alu_op_e     dec_alu_op_out_reg,
	output alu_cnd_e    dec_alu_cnd_out_reg,
	output hazard_cmd_e dec_hazard_cmd_out_reg,
	output logic        dec_l1d_req_val_out_reg,  // Data L1 request
	output logic        dec_l1d_req_wr_out_reg,
	output mem_size_e   dec_l1d_req_size_out_reg,
	output word_t       dec_src1_out_reg,
	output word_t       dec_src2_out_reg,
	output word_t       dec_imm_out_reg,
	output word_t       dec_pc_out_reg,
	output word_t       dec_pc_4_out_reg,
	output reg_idx_t    dec_rs1_out_reg,
	output reg_idx_t    dec_rs2_out_reg,
	output reg_idx_t    dec_rd_out_reg,
	output hazard_cmd_e dec2haz_cmd_out,
	output logic        dec_stall_out
);

	// Port names match the station one to one
	core_dec_s u_dec (.*);

endmodule

`default_nettype wire

//--- hw/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ---------------------------------------------------------------------------
// Core sizing
// ---------------------------------------------------------------------------

// Width of data and PC words
`define CORE_XLEN       32

// Architectural registers, x0 included
`define CORE_REG_NUM    32

// Bits to address one register
`define CORE_REG_IDX_W  5

// ---------------------------------------------------------------------------
// Reset values
// ---------------------------------------------------------------------------

`define CORE_RESET_PC   32'h0000_0000  // PC registers after arst_n

`endif

//--- hw/core_imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module core_imm_gen
	import core_isa_pkg::*;
(
	input  inst_t     inst,
	input  imm_kind_e kind,
	output word_t     imm
);

	// Bit reassembly per format, inst[31] is always the sign
	always_comb begin
		case (kind)
			IMM_I: begin
				imm = {{20{inst[31]}}, inst[31:20]};
			end
			IMM_U: begin
				imm = {inst[31:12], 12'b0};
			end
			IMM_S: begin
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			IMM_B: begin
				// Offset in halfwords, low bit implied
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			IMM_J: begin
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: begin
				imm = '0;  // IMM_NONE
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/core_isa_pkg.sv
`default_nettype none
`include "core_defines.svh"

package core_isa_pkg;

	typedef logic [`CORE_XLEN-1:0]      word_t;
	typedef logic [31:0]                inst_t;     // RV32I, fixed 32-bit encoding
	typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;
	typedef logic [2:0]                 funct3_t;

	// ---------------------------------------------------------------------------
	// Major opcodes, inst[6:0]
	// ---------------------------------------------------------------------------
	typedef enum logic [6:0] {
		OPC_R     = 7'b0110011,
		OPC_I_R   = 7'b0010011,
		OPC_LUI   = 7'b0110111,
		OPC_AUIPC = 7'b0010111,
		OPC_SB    = 7'b1100011,  // Conditional branches
		OPC_UJ    = 7'b1101111,  // JAL
		OPC_JALR  = 7'b1100111,
		OPC_LD    = 7'b0000011,
		OPC_ST    = 7'b0100011
	} opcode_e;

	typedef enum logic [6:0] {
		F7_BASE = 7'b0000000,
		F7_ALT  = 7'b0100000   // SUB and SRA
	} funct7_e;

	// Immediate format picked by the control unit
	typedef enum logic [2:0] {
		IMM_NONE,
		IMM_I,
		IMM_U,
		IMM_B,
		IMM_J,
		IMM_S
	} imm_kind_e;

	// funct3 codes, grouped by instruction class
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101;  // SRL or SRA by funct7
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam funct3_t F3_LB   = 3'b000;
	localparam funct3_t F3_LH   = 3'b001;
	localparam funct3_t F3_LW   = 3'b010;
	localparam funct3_t F3_LBU  = 3'b100;
	localparam funct3_t F3_LHU  = 3'b101;

	localparam funct3_t F3_SB   = 3'b000;
	localparam funct3_t F3_SH   = 3'b001;
	localparam funct3_t F3_SW   = 3'b010;

endpackage

`default_nettype wire

//--- hw/core_reg_file.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

module core_reg_file
	import core_isa_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  reg_idx_t rd,
	input  logic     we,
	input  word_t    data_in,
	input  logic     order,
	output word_t    src1_out,
	output word_t    src2_out
);

	word_t regs [1:`CORE_REG_NUM-1];  // x0 has no storage
	word_t rd1;
	word_t rd2;

	// Writeback port
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < `CORE_REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= data_in;
		end
	end

	// ---------------------------------------------------------------------------
	// Read ports, forwarding a same-cycle writeback
	// ---------------------------------------------------------------------------
	function automatic word_t read_port(reg_idx_t idx);
		if (idx == '0)
			return '0;
		if (we && idx == rd)
			return data_in;  // Write-through
		return regs[idx];
	endfunction

	always_comb begin
		rd1 = read_port(rs1);
		rd2 = read_port(rs2);
	end

	// Swapped order lets execute reuse LT/LTU for BGE/BGEU
	assign src1_out = order ? rd2 : rd1;
	assign src2_out = order ? rd1 : rd2;

endmodule

`default_nettype wire

//--- testbench/core_dec_chk.sv
`timescale 1ns/1ns
`default_nettype none

module core_dec_chk
	import core_isa_pkg::*;
	import core_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        dec_kill,
	input  logic        dec_il1_ack_in,
	input  logic        dec_stall_out,
	input  wb_ext_e     dec_wb_ext_out_reg,
	input  mux_sel_e    dec_mux_bus_out_reg,
	input  logic        dec_we_reg_file_out_reg,
	input  alu_op_e     dec_alu_op_out_reg,
	input  alu_cnd_e    dec_alu_cnd_out_reg,
	input  hazard_cmd_e dec_hazard_cmd_out_reg,
	input  logic        dec_l1d_req_val_out_reg,
	input  logic        dec_l1d_req_wr_out_reg,
	input  mem_size_e   dec_l1d_req_size_out_reg,
	input  word_t       dec_src1_out_reg,
	input  word_t       dec_src2_out_reg,
	input  word_t       dec_imm_out_reg,
	input  word_t       dec_pc_out_reg,
	input  word_t       dec_pc_4_out_reg,
	input  reg_idx_t    dec_rs1_out_reg,
	input  reg_idx_t    dec_rs2_out_reg,
	input  reg_idx_t    dec_rd_out_reg
);

	// ------------------------------------------------------------------------
	// Output bank after a flush
	// ------------------------------------------------------------------------
	property kill_clears_outputs;
		@(posedge clk) disable iff (!arst_n)
		dec_kill |=> ({dec_wb_ext_out_reg, dec_mux_bus_out_reg, dec_we_reg_file_out_reg,
			dec_alu_op_out_reg, dec_alu_cnd_out_reg, dec_hazard_cmd_out_reg,
			dec_l1d_req_val_out_reg, dec_l1d_req_wr_out_reg, dec_l1d_req_size_out_reg,
			dec_src1_out_reg, dec_src2_out_reg, dec_imm_out_reg, dec_pc_out_reg,
			dec_pc_4_out_reg, dec_rs1_out_reg, dec_rs2_out_reg, dec_rd_out_reg} == '0);
	endproperty

	property store_never_writes_back;
		@(posedge clk) disable iff (!arst_n)
		(dec_mux_bus_out_reg == MUX_ST) |-> !(dec_l1d_req_val_out_reg && dec_we_reg_file_out_reg);
	endproperty

	assert property (kill_clears_outputs)
		else $error("Output registers not cleared after kill");
	assert property (store_never_writes_back)
		else $error("Store with memory valid also writes the register file");
	assert property (@(posedge clk) dec_stall_out == ~dec_il1_ack_in)
		else $error("Stall does not follow the inverted I-L1 acknowledge");

endmodule

bind core_dec_s core_dec_chk u_chk (.*);

`default_nettype wire

//--- testbench/dec_input.txt
# enb kill nop ack wbwe wbrd wbdata inst rnd pc | wbext mux we alu cnd haz val wr size
# src1 src2 imm pc pc4 rs1 rs2 rd hazcomb (all hex, pc ignored when rnd is 1)
1 0 0 1 1 1 5 00000013 0 100  0 2 1 0 0 0 0 0 0 0 0 0 100 104 0 0 0 0
1 0 0 1 1 2 fffffff0 00000013 0 104  0 2 1 0 0 0 0 0 0 0 0 0 104 108 0 0 0 0
1 0 0 1 1 3 1234 00000013 0 108  0 2 1 0 0 0 0 0 0 0 0 0 108 10c 0 0 0 0
1 0 0 1 0 0 0 00208233 0 10c  0 1 1 0 0 0 0 0 0 5 fffffff0 0 10c 110 1 2 4 0
1 0 0 1 0 0 0 401182b3 0 110  0 1 1 1 0 0 0 0 0 1234 5 0 110 114 3 1 5 0
1 0 0 1 0 0 0 40315333 1 0  0 1 1 9 0 0 0 0 0 fffffff0 1234 0 0 0 2 3 6 0
1 0 0 1 0 0 0 0020b3b3 0 118  0 1 1 3 0 0 0 0 0 5 fffffff0 0 118 11c 1 2 7 0
1 0 0 1 0 0 0 fff0c413 0 11c  0 2 1 6 0 0 0 0 0 5 0 ffffffff 11c 120 1 1f 8 0
1 0 0 1 0 0 0 00512493 0 120  0 2 1 2 0 0 0 0 0 fffffff0 0 5 120 124 2 5 9 0
1 0 0 1 0 0 0 4041d513 0 124  0 2 1 9 0 0 0 0 0 1234 0 404 124 128 3 4 a 0
1 0 0 1 0 0 0 ffc0a583 0 128  0 8 1 0 0 1 1 0 2 5 0 fffffffc 128 12c 1 1c b 1
1 0 0 1 0 0 0 0021d603 0 12c  4 8 1 0 0 1 1 0 1 1234 fffffff0 2 12c 130 3 2 c 1
1 0 0 1 0 0 0 00010683 0 130  1 8 1 0 0 1 1 0 0 fffffff0 0 0 130 134 2 0 d 1
1 0 0 1 0 0 0 0020a423 0 134  0 9 0 0 0 0 1 1 2 5 fffffff0 8 134 138 1 2 8 0
1 0 0 1 0 0 0 fe310fa3 0 138  1 9 0 0 0 0 1 1 0 fffffff0 1234 ffffffff 138 13c 2 3 1f 0
1 0 0 1 0 0 0 00208463 0 13c  0 5 0 0 1 2 0 0 0 5 fffffff0 8 13c 140 1 2 8 2
1 0 0 1 0 0 0 0020d463 0 140  0 5 0 0 3 2 0 0 0 fffffff0 5 8 140 144 1 2 8 2
1 0 0 1 0 0 0 fe11fee3 0 144  0 5 0 0 4 2 0 0 0 5 1234 fffffffc 144 148 3 1 1d 2
1 0 0 1 0 0 0 010000ef 1 0  6 6 1 0 0 3 0 0 0 0 0 10 0 0 0 10 1 3
1 0 0 1 0 0 0 00418067 0 14c  6 7 1 0 0 3 0 0 0 1234 0 4 14c 150 3 4 0 3
1 0 0 1 0 0 0 123452b7 0 150  5 3 1 0 0 0 0 0 0 0 1234 12345000 150 154 8 3 5 0
1 0 0 1 0 0 0 fffff317 0 154  0 4 1 0 0 0 0 0 0 0 0 fffff000 154 158 1f 1f 6 0
1 0 0 1 1 1 abcd 00208233 0 158  0 1 1 0 0 0 0 0 0 abcd fffffff0 0 158 15c 1 2 4 0
1 0 0 1 1 0 ff 00100233 0 15c  0 1 1 0 0 0 0 0 0 0 abcd 0 15c 160 0 1 4 0
0 0 0 0 0 0 0 401182b3 0 200  0 1 1 0 0 0 0 0 0 0 abcd 0 15c 160 0 1 4 0
1 1 0 1 0 0 0 ffc0a583 0 204  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
1 0 1 1 0 0 0 0020b3b3 0 208  0 1 0 3 0 0 0 0 0 0 0 0 208 20c 0 0 0 0
1 0 1 1 0 0 0 0020a423 0 20c  0 9 0 0 0 0 0 1 2 0 0 8 20c 210 0 0 0 0
1 0 0 1 0 0 0 00000013 0 210  0 2 1 0 0 0 0 0 0 0 0 0 210 214 0 0 0 0

//--- testbench/tb_core_dec.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

module tb_core_dec
	import core_isa_pkg::*;
	import core_ctrl_pkg::*;
();

	localparam int MAX_LINES = 64;
	localparam int NF        = 28;  // Fields per vector line

	logic        clk;
	logic        arst_n;
	logic        dec_enb;
	logic        dec_kill;
	logic        dec_nop_gen_in;
	logic        dec_il1_ack_in;
	inst_t       dec_inst_in;
	word_t       dec_pc_in;
	word_t       dec_pc_4_in;
	logic        wb_we;
	reg_idx_t    wb_rd;
	word_t       wb_data;
	wb_ext_e     dec_wb_ext_out_reg;
	mux_sel_e    dec_mux_bus_out_reg;
	logic        dec_we_reg_file_out_reg;
	alu_op_e     dec_alu_op_out_reg;
	alu_cnd_e    dec_alu_cnd_out_reg;
	hazard_cmd_e dec_hazard_cmd_out_reg;
	logic        dec_l1d_req_val_out_reg;
	logic        dec_l1d_req_wr_out_reg;
	mem_size_e   dec_l1d_req_size_out_reg;
	word_t       dec_src1_out_reg;
	word_t       dec_src2_out_reg;
	word_t       dec_imm_out_reg;
	word_t       dec_pc_out_reg;
	word_t       dec_pc_4_out_reg;
	reg_idx_t    dec_rs1_out_reg;
	reg_idx_t    dec_rs2_out_reg;
	reg_idx_t    dec_rd_out_reg;
	hazard_cmd_e dec2haz_cmd_out;
	logic        dec_stall_out;

	logic [31:0] vec [MAX_LINES][NF];
	word_t       pc_drv [MAX_LINES];  // PC actually driven per line
	int          nlines;
	int          errors;
	int          cycles;
	int          limit;

	core_dec_top DUT (.*);

	always #4 clk = ~clk;

	// Run guard
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: no end of run after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] act,
			input logic [31:0] exp, input int ln);
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h (vector %0d)", name, act, exp, ln);
		end
	endtask

	task automatic read_vectors();
		int          fd;
		int          cnt;
		string       line;
		logic [31:0] f [NF];
		fd = $fopen("testbench/dec_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file testbench/dec_input.txt");
			errors++;
		end else begin
			while (!$feof(fd) && nlines < MAX_LINES) begin
				line = "";
				cnt = $fgets(line, fd);
				if (line.len() < 2 || line[0] == 8'h23)
					continue;
				cnt = $sscanf(line,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
					f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
					f[22], f[23], f[24], f[25], f[26], f[27]);
				if (cnt != NF) begin
					$display("Vector line %0d is short: %0d of %0d fields", nlines + 1, cnt, NF);
					errors++;
				end else begin
					for (int k = 0; k < NF; k++)
						vec[nlines][k] = f[k];
					nlines++;
				end
			end
			$fclose(fd);
			if (nlines == 0) begin
				$display("The vector file holds no vectors");
				errors++;
			end
		end
	endtask

	task automatic drive_line(input int i);
		dec_enb        = vec[i][0][0];
		dec_kill       = vec[i][1][0];
		dec_nop_gen_in = vec[i][2][0];
		dec_il1_ack_in = vec[i][3][0];
		wb_we          = vec[i][4][0];
		wb_rd          = vec[i][5][4:0];
		wb_data        = vec[i][6];
		dec_inst_in    = vec[i][7];
		dec_pc_in      = (vec[i][8] != 0) ? ($urandom & 32'hffff_fffc) : vec[i][9];
		dec_pc_4_in    = dec_pc_in + 32'd4;
		pc_drv[i]      = dec_pc_in;
	endtask

	task automatic check_regs(input int i);
		logic [31:0] epc;
		logic [31:0] epc4;
		epc  = vec[i][22];
		epc4 = vec[i][23];
		if (vec[i][8] != 0) begin
			epc  = pc_drv[i];      // Random PC, expect what was driven
			epc4 = pc_drv[i] + 32'd4;
		end
		compare("dec_wb_ext_out_reg", 32'(dec_wb_ext_out_reg), vec[i][10], i + 1);
		compare("dec_mux_bus_out_reg", 32'(dec_mux_bus_out_reg), vec[i][11], i + 1);
		compare("dec_we_reg_file_out_reg", 32'(dec_we_reg_file_out_reg), vec[i][12], i + 1);
		compare("dec_alu_op_out_reg", 32'(dec_alu_op_out_reg), vec[i][13], i + 1);
		compare("dec_alu_cnd_out_reg", 32'(dec_alu_cnd_out_reg), vec[i][14], i + 1);
		compare("dec_hazard_cmd_out_reg", 32'(dec_hazard_cmd_out_reg), vec[i][15], i + 1);
		compare("dec_l1d_req_val_out_reg", 32'(dec_l1d_req_val_out_reg), vec[i][16], i + 1);
		compare("dec_l1d_req_wr_out_reg", 32'(dec_l1d_req_wr_out_reg), vec[i][17], i + 1);
		compare("dec_l1d_req_size_out_reg", 32'(dec_l1d_req_size_out_reg), vec[i][18], i + 1);
		compare("dec_src1_out_reg", dec_src1_out_reg, vec[i][19], i + 1);
		compare("dec_src2_out_reg", dec_src2_out_reg, vec[i][20], i + 1);
		compare("dec_imm_out_reg", dec_imm_out_reg, vec[i][21], i + 1);
		compare("dec_pc_out_reg", dec_pc_out_reg, epc, i + 1);
		compare("dec_pc_4_out_reg", dec_pc_4_out_reg, epc4, i + 1);
		compare("dec_rs1_out_reg", 32'(dec_rs1_out_reg), vec[i][24], i + 1);
		compare("dec_rs2_out_reg", 32'(dec_rs2_out_reg), vec[i][25], i + 1);
		compare("dec_rd_out_reg", 32'(dec_rd_out_reg), vec[i][26], i + 1);
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(32'h55ff_426e));
		clk            = 1'b0;
		arst_n         = 1'b0;
		dec_enb        = 1'b0;
		dec_kill       = 1'b0;
		dec_nop_gen_in = 1'b0;
		dec_il1_ack_in = 1'b1;
		dec_inst_in    = '0;
		dec_pc_in      = '0;
		dec_pc_4_in    = '0;
		wb_we          = 1'b0;
		wb_rd          = '0;
		wb_data        = '0;
		errors         = 0;
		cycles         = 0;
		nlines         = 0;
		limit          = 20;
		read_vectors();
		limit = nlines + 20;
		repeat (3) @(posedge clk);
		#1 arst_n = 1'b1;
		compare("dec_we_reg_file_out_reg", 32'(dec_we_reg_file_out_reg), 32'd0, 0);
		compare("dec_l1d_req_val_out_reg", 32'(dec_l1d_req_val_out_reg), 32'd0, 0);
		compare("dec_pc_out_reg", dec_pc_out_reg, `CORE_RESET_PC, 0);
		for (int i = 0; i < nlines; i++) begin
			@(posedge clk);
			#1;
			if (i > 0)
				check_regs(i - 1);
			drive_line(i);
			#1;
			compare("dec2haz_cmd_out", 32'(dec2haz_cmd_out), vec[i][27], i + 1);
			if (dec_stall_out !== !vec[i][3][0]) begin
				errors++;
				$display("FAIL dec_stall_out: got %h, expected %h (vector %0d)",
					dec_stall_out, !vec[i][3][0], i + 1);
			end
		end
		if (nlines > 0) begin
			@(posedge clk);
			#1 check_regs(nlines - 1);
		end
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
